/* Bender.yml */
package:
  name: lsu

sources:
  - hw/lsu_pkg.sv
  - hw/lsu_req_decode.sv
  - hw/lsu_axi_master.sv
  - hw/lsu_load_format.sv
  - hw/axi_sram.sv
  - hw/lsu_top.sv
  - target: simulation
    files:
      - testbench/tb_lsu_top.sv

/* filelist.f */
hw/lsu_pkg.sv
hw/lsu_req_decode.sv
hw/lsu_axi_master.sv
hw/lsu_load_format.sv
hw/axi_sram.sv
hw/lsu_top.sv
testbench/tb_lsu_top.sv

/* hw/axi_sram.sv */
`default_nettype none

module axi_sram (
  input  logic             clk,
  input  logic             rst,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  lsu_pkg::axi_aw_t aw,
  input  logic             w_valid,
  output logic             w_ready,
  input  lsu_pkg::axi_w_t  w,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  lsu_pkg::axi_ar_t ar,
  output logic             r_valid,
  input  logic             r_ready,
  output lsu_pkg::axi_r_t  r,
  output logic             b_valid,
  input  logic             b_ready,
  output lsu_pkg::axi_b_t  b
);

  import lsu_pkg::*;

  logic [7:0]           lfsr;
  logic [DATA_W-1:0]    mem [MEM_DEPTH];
  logic [2:0]           ch_valid;    // ar, w, aw
  logic [2:0]           ch_ready;
  logic [2:0]           armed;
  logic [2:0][1:0]      stall_cnt;
  logic                 have_aw;
  logic                 have_w;
  axi_aw_t              aw_q;
  axi_w_t               w_q;
  axi_aw_t              aw_cur;
  axi_w_t               w_cur;
  logic                 wr_go;
  logic                 wr_in;
  logic                 rd_in;
  logic [MEM_IDX_W-1:0] wr_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ready stalls

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= 8'hA5;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  // One transfer at a time per direction
  assign ch_valid = {aw_valid & ~have_aw & ~b_valid,
                     w_valid & ~have_w & ~b_valid,
                     ar_valid & ~r_valid};

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      ch_ready[i] = ch_valid[i] &
                    (armed[i] ? (stall_cnt[i] == 2'd0) : (lfsr[2*i +: 2] == 2'd0));
    end
  end

  assign {aw_ready, w_ready, ar_ready} = ch_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (ch_valid[i] && !ch_ready[i]) begin
          if (armed[i]) begin
            stall_cnt[i] <= stall_cnt[i] - 2'd1;
          end else begin
            armed[i]     <= 1'b1;
            stall_cnt[i] <= lfsr[2*i +: 2] - 2'd1; // 1 to 3 wait cycles
          end
        end else if (ch_ready[i]) begin
          armed[i] <= 1'b0;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write and read paths

  assign aw_cur = have_aw ? aw_q : aw;
  assign w_cur  = have_w ? w_q : w;
  assign wr_go  = (have_aw | aw_ready) & (have_w | w_ready);
  assign wr_idx = aw_cur.addr[2 +: MEM_IDX_W];
  assign wr_in  = aw_cur.addr[ADDR_W-1:2] < MEM_DEPTH;
  assign rd_in  = ar.addr[ADDR_W-1:2] < MEM_DEPTH;

  always_ff @(posedge clk) begin
    if (rst) begin
      have_aw <= 1'b0;
      have_w  <= 1'b0;
      b_valid <= 1'b0;
      r_valid <= 1'b0;
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (aw_ready) have_aw <= 1'b1;
      if (w_ready)  have_w  <= 1'b1;

      if (wr_go) begin
        have_aw <= 1'b0;
        have_w  <= 1'b0;
        b_valid <= 1'b1;
        if (wr_in) begin
          for (int k = 0; k < STRB_W; k++) begin
            if (w_cur.strb[k]) mem[wr_idx][8*k +: 8] <= w_cur.data[8*k +: 8];
          end
        end
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end

      if (ar_ready) begin
        r_valid <= 1'b1;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_ready) aw_q <= aw;
    if (w_ready)  w_q  <= w;
    if (wr_go) begin
      b.resp <= wr_in ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_ready) begin
      r.data <= rd_in ? mem[ar.addr[2 +: MEM_IDX_W]] : '0;
      r.resp <= rd_in ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_axi_master.sv */
`default_nettype none

module lsu_axi_master (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  bus_valid,
  input  lsu_pkg::lsu_bus_req_t bus_req,
  output logic                  aw_valid,
  input  logic                  aw_ready,
  output lsu_pkg::axi_aw_t      aw,
  output logic                  w_valid,
  input  logic                  w_ready,
  output lsu_pkg::axi_w_t       w,
  output logic                  ar_valid,
  input  logic                  ar_ready,
  output lsu_pkg::axi_ar_t      ar,
  input  logic                  r_valid,
  output logic                  r_ready,
  input  lsu_pkg::axi_r_t       r,
  input  logic                  b_valid,
  output logic                  b_ready,
  input  lsu_pkg::axi_b_t       b,
  output logic                  xfer_done,
  output lsu_pkg::lsu_xfer_t    xfer
);

  import lsu_pkg::*;

  logic              aw_pend;
  logic              w_pend;
  logic              ar_pend;
  logic              r_hs;
  logic              b_hs;
  lsu_bus_req_t      meta_q;
  logic [DATA_W-1:0] rdata_q;
  logic              fault_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address and data channels

  // A channel stays valid until its own handshake
  assign aw_valid = (bus_valid & bus_req.is_store) | aw_pend;
  assign w_valid  = (bus_valid & bus_req.is_store) | w_pend;
  assign ar_valid = (bus_valid & ~bus_req.is_store) | ar_pend;

  // Decoder holds bus_req, so payloads are stable while valid
  assign aw.addr = bus_req.addr;
  assign w.data  = bus_req.wdata;
  assign w.strb  = bus_req.wstrb;
  assign ar.addr = bus_req.addr;

  assign r_hs = r_valid & r_ready;
  assign b_hs = b_valid & b_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_pend   <= 1'b0;
      w_pend    <= 1'b0;
      ar_pend   <= 1'b0;
      r_ready   <= 1'b0;
      b_ready   <= 1'b0;
      xfer_done <= 1'b0;
    end else begin
      aw_pend   <= aw_valid & ~aw_ready;
      w_pend    <= w_valid & ~w_ready;
      ar_pend   <= ar_valid & ~ar_ready;
      r_ready   <= 1'b1;
      b_ready   <= 1'b1;
      xfer_done <= r_hs | b_hs; // Read ends on r, write on b
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response capture

  always_ff @(posedge clk) begin
    if (bus_valid) begin
      meta_q <= bus_req;
    end
    if (r_hs) begin
      rdata_q <= r.data;
      fault_q <= |r.resp;
    end else if (b_hs) begin
      fault_q <= |b.resp;
    end
  end

  assign xfer.meta          = meta_q;
  assign xfer.resp.rdata    = rdata_q;
  assign xfer.resp.fault    = fault_q;
  assign xfer.resp.is_store = meta_q.is_store;

endmodule

`default_nettype wire

/* hw/lsu_load_format.sv */
`default_nettype none

module lsu_load_format (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  xfer_done,
  input  lsu_pkg::mem_word_u    xfer_word,
  input  lsu_pkg::lsu_bus_req_t xfer_meta,
  input  logic                  xfer_fault,
  output logic                  resp_valid,
  output lsu_pkg::lsu_resp_t    resp
);

  import lsu_pkg::*;

  logic [7:0]        lane_b;
  logic [15:0]       lane_h;
  logic [DATA_W-1:0] ext;

  always_comb begin
    lane_b = xfer_word.bytes[xfer_meta.byte_off];
    lane_h = xfer_word.halves[xfer_meta.byte_off[1]];

    case (xfer_meta.size)
      SIZE_B:  ext = {{24{xfer_meta.is_signed & lane_b[7]}}, lane_b};
      SIZE_H:  ext = {{16{xfer_meta.is_signed & lane_h[15]}}, lane_h};
      default: ext = xfer_word; // Whole word
    endcase

    if (xfer_meta.is_store) begin
      ext = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= xfer_done;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_done) begin
      resp.rdata    <= ext;
      resp.fault    <= xfer_fault;
      resp.is_store <= xfer_meta.is_store;
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int MEM_DEPTH = 256;
  localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } lsu_size_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute side and decoded requests

  typedef struct packed {
    logic              is_store;
    lsu_size_e         size;
    logic              is_signed;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic              is_store;
    logic [ADDR_W-1:0] addr;      // Word aligned
    logic [DATA_W-1:0] wdata;     // Already in its lanes
    logic [STRB_W-1:0] wstrb;
    lsu_size_e         size;
    logic              is_signed;
    logic [1:0]        byte_off;
  } lsu_bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              fault;
    logic              is_store;
  } lsu_resp_t;

  // Master result with the request it belongs to
  typedef struct packed {
    lsu_resp_t    resp;
    lsu_bus_req_t meta;
  } lsu_xfer_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI-Lite channel payloads

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

endpackage

`default_nettype wire

/* hw/lsu_req_decode.sv */
`default_nettype none

module lsu_req_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  lsu_pkg::lsu_req_t     req,
  output logic                  bus_valid,
  output lsu_pkg::lsu_bus_req_t bus_req
);

  import lsu_pkg::*;

  lsu_bus_req_t dec;
  logic [1:0]   off;

  always_comb begin
    // Low address bits below the access size are dropped
    case (req.size)
      SIZE_B: begin
        off       = req.addr[1:0];
        dec.wstrb = STRB_W'(1) << off;
      end
      SIZE_H: begin
        off       = {req.addr[1], 1'b0};
        dec.wstrb = STRB_W'(3) << off;
      end
      default: begin
        off       = 2'b00;
        dec.wstrb = {STRB_W{1'b1}};
      end
    endcase

    dec.is_store  = req.is_store;
    dec.addr      = {req.addr[ADDR_W-1:2], 2'b00};
    dec.wdata     = req.wdata << {off, 3'b000}; // Into the addressed lanes
    dec.size      = req.size;
    dec.is_signed = req.is_signed;
    dec.byte_off  = off;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_valid <= 1'b0;
    end else begin
      bus_valid <= req_valid;
    end
  end

  // Held until the next request so the AXI payloads stay stable
  always_ff @(posedge clk) begin
    if (req_valid) begin
      bus_req <= dec;
    end
  end

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`default_nettype none

module lsu_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  lsu_pkg::lsu_req_t  req,
  output logic               resp_valid,
  output lsu_pkg::lsu_resp_t resp
);

  import lsu_pkg::*;

  logic         bus_valid;
  lsu_bus_req_t bus_req;
  logic         aw_valid, aw_ready;
  logic         w_valid, w_ready;
  logic         ar_valid, ar_ready;
  logic         r_valid, r_ready;
  logic         b_valid, b_ready;
  axi_aw_t      aw;
  axi_w_t       w;
  axi_ar_t      ar;
  axi_r_t       r;
  axi_b_t       b;
  logic         xfer_done;
  lsu_xfer_t    xfer;

  lsu_req_decode u_decode (
    .clk, .rst, .req_valid, .req, .bus_valid, .bus_req
  );

  lsu_axi_master u_master (
    .clk, .rst, .bus_valid, .bus_req,
    .aw_valid, .aw_ready, .aw,
    .w_valid, .w_ready, .w,
    .ar_valid, .ar_ready, .ar,
    .r_valid, .r_ready, .r,
    .b_valid, .b_ready, .b,
    .xfer_done, .xfer
  );

  lsu_load_format u_format (
    .clk,
    .rst,
    .xfer_done,
    .xfer_word  (xfer.resp.rdata),
    .xfer_meta  (xfer.meta),
    .xfer_fault (xfer.resp.fault),
    .resp_valid,
    .resp
  );

  axi_sram u_sram (
    .clk, .rst,
    .aw_valid, .aw_ready, .aw,
    .w_valid, .w_ready, .w,
    .ar_valid, .ar_ready, .ar,
    .r_valid, .r_ready, .r,
    .b_valid, .b_ready, .b
  );

endmodule

`default_nettype wire

/* testbench/lsu_testdata.txt */
# is_store size is_signed addr wdata exp_rdata exp_fault, all hex
# size 0 byte, 1 halfword, 2 word
1 2 0 00000010 deadbeef 00000000 0
0 2 0 00000010 00000000 deadbeef 0
0 0 1 00000010 00000000 ffffffef 0
0 0 0 00000011 00000000 000000be 0
0 0 1 00000012 00000000 ffffffad 0
0 0 0 00000013 00000000 000000de 0
0 0 0 00000010 00000000 000000ef 0
0 0 1 00000013 00000000 ffffffde 0
0 1 1 00000010 00000000 ffffbeef 0
0 1 0 00000012 00000000 0000dead 0
0 1 0 00000011 00000000 0000beef 0
0 1 1 00000013 00000000 ffffdead 0
1 2 0 00000020 a5a5a5a5 00000000 0
1 0 0 00000020 ffffff11 00000000 0
0 2 0 00000020 00000000 a5a5a511 0
1 0 0 00000021 ffffff22 00000000 0
1 0 0 00000022 ffffff33 00000000 0
1 0 0 00000023 ffffff84 00000000 0
0 2 0 00000020 00000000 84332211 0
0 0 1 00000023 00000000 ffffff84 0
1 1 0 00000032 0000f00d 00000000 0
0 1 1 00000032 00000000 fffff00d 0
0 1 0 00000032 00000000 0000f00d 0
0 1 0 00000030 00000000 00000000 0
1 2 0 00000000 0badf00d 00000000 0
1 2 0 00000400 12345678 00000000 1
1 0 0 00000fff 000000ee 00000000 1
0 2 0 00000400 00000000 00000000 1
0 2 0 00000000 00000000 0badf00d 0
0 0 1 00000003 00000000 0000000b 0

/* testbench/tb_lsu_top.sv */
`default_nettype none

module tb_lsu_top;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int RESP_TIMEOUT = 200;

  logic      clk;
  logic      rst;
  logic      req_valid;
  lsu_req_t  req;
  logic      resp_valid;
  lsu_resp_t resp;

  int err_cnt;
  int timeout_cnt;
  int resp_cnt;

  lsu_top DUT (
    .clk, .rst, .req_valid, .req, .resp_valid, .resp
  );

  always #5 clk = ~clk;

  // Response strobes seen since reset
  always @(negedge clk) begin
    if (rst) begin
      resp_cnt <= 0;
    end else if (resp_valid) begin
      resp_cnt <= resp_cnt + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks

  task automatic check_resp(input lsu_resp_t got, input lsu_resp_t exp_resp);
    if (got.rdata !== exp_resp.rdata) begin
      $display("FAIL %0t resp.rdata got %h expected %h", $time, got.rdata, exp_resp.rdata);
      err_cnt++;
    end
    if (got.is_store !== exp_resp.is_store) begin
      $display("FAIL %0t resp.is_store got %b expected %b", $time,
               got.is_store, exp_resp.is_store);
      err_cnt++;
    end
  endtask

  task automatic check_fault(input logic got, input logic exp_fault);
    if (got !== exp_fault) begin
      $display("FAIL %0t resp.fault got %b expected %b", $time, got, exp_fault);
      err_cnt++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request driving

  task automatic send_req(input lsu_req_t r);
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
    @(posedge clk);
    req_valid <= 1'b0; // Single cycle strobe
  endtask

  task automatic wait_resp(output logic timed_out);
    int n;
    timed_out = 1'b1;
    for (n = 0; n < RESP_TIMEOUT; n++) begin
      @(negedge clk);
      if (resp_valid) begin
        timed_out = 1'b0;
        break;
      end
    end
  endtask

  initial begin
    int          fd;
    int          n_fields;
    int          n_sent;
    string       line;
    logic [31:0] f_st;
    logic [31:0] f_sz;
    logic [31:0] f_sg;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_rdata;
    logic [31:0] f_fault;
    lsu_req_t    r;
    lsu_resp_t   exp_resp;
    logic        timed_out;

    clk         = 1'b0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    n_sent      = 0;
    timed_out   = 1'b0;

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("testbench/lsu_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/lsu_testdata.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n_fields = $sscanf(line, "%h %h %h %h %h %h %h",
                           f_st, f_sz, f_sg, f_addr, f_wdata, f_rdata, f_fault);
        if (n_fields <= 0) begin
          continue; // Blank line
        end
        if (n_fields != 7) begin
          $display("Vector line has %0d fields instead of 7: %0s", n_fields, line);
          err_cnt++;
          continue;
        end

        r.is_store         = f_st[0];
        r.size             = lsu_size_e'(f_sz[1:0]);
        r.is_signed        = f_sg[0];
        r.addr             = f_addr;
        r.wdata            = f_wdata;
        exp_resp.rdata     = f_rdata;
        exp_resp.fault     = f_fault[0];
        exp_resp.is_store  = f_st[0];

        send_req(r);
        n_sent++;
        wait_resp(timed_out);
        if (timed_out) begin
          $display("No response within %0d cycles for request %0d at address %h",
                   RESP_TIMEOUT, n_sent, f_addr);
          timeout_cnt++;
        end else begin
          check_resp(resp, exp_resp);
          check_fault(resp.fault, exp_resp.fault);
        end
      end
      $fclose(fd);
    end

    if (n_sent == 0) begin
      $display("No requests were read from the vector file");
      err_cnt++;
    end

    repeat (10) @(negedge clk);
    if (resp_cnt != n_sent) begin
      $display("Sent %0d requests but saw %0d responses", n_sent, resp_cnt);
      err_cnt++;
    end

    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
